// ==== hdl/miss_params.svh ====
`ifndef MISS_PARAMS_SVH
`define MISS_PARAMS_SVH

// physical address and data word
`define ADDR_BITS 32
`define WORD_BITS 32

// line geometry
`define LINE_WORDS 4
`define WORD_OFFSET_BITS 2
`define WORD_BYTES (`WORD_BITS / 8)
`define BYTE_OFFSET_BITS 2
`define LINE_OFFSET_BITS (`WORD_OFFSET_BITS + `BYTE_OFFSET_BITS)

// queue depths
`define MISS_ENTRIES 4
`define LOAD_RECORDS 4

// load queue tag
`define LQ_TAG_BITS 5

`endif

// ==== hdl/miss_pkg.sv ====
`include "miss_params.svh"

package miss_pkg;

    typedef logic [`WORD_BITS-1:0] word_t;

    typedef word_t [`LINE_WORDS-1:0] line_data_t;

    // one enable per byte of the line
    typedef logic [`LINE_WORDS*`WORD_BYTES-1:0] line_mask_t;

    typedef logic [`ADDR_BITS-`LINE_OFFSET_BITS-1:0] line_addr_t;

    typedef logic [$clog2(`MISS_ENTRIES)-1:0] miss_idx_t;

    typedef logic [`WORD_OFFSET_BITS-1:0] word_sel_t;

    typedef logic [`LQ_TAG_BITS-1:0] lq_tag_t;

    typedef enum logic [2:0] {
        fill_idle,
        fill_request,
        fill_collect,
        fill_refill,
        fill_wake
    } fill_state_t;

endpackage

// ==== hdl/line_queue.sv ====
`timescale 1ns/1ns
`include "miss_params.svh"

module line_queue (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  load_req,
    input  logic [`ADDR_BITS-1:0] load_addr,
    input  logic                  store_req,
    input  logic [`ADDR_BITS-1:0] store_addr,
    input  miss_pkg::line_data_t  store_data,
    input  miss_pkg::line_mask_t  store_mask,
    input  logic                  record_free,
    input  logic                  fetch_busy,
    input  logic                  line_retire,
    output logic                  load_accept,
    output miss_pkg::miss_idx_t   load_idx,
    output logic                  load_full,
    output logic                  store_full,
    output logic                  head_valid,
    output miss_pkg::miss_idx_t   head_idx,
    output miss_pkg::line_addr_t  head_addr,
    output miss_pkg::line_data_t  head_data,
    output miss_pkg::line_mask_t  head_mask,
    output logic                  head_dirty
);
    localparam int COUNT_BITS = $clog2(`MISS_ENTRIES) + 1;

    logic [`MISS_ENTRIES-1:0] entry_valid;
    miss_pkg::line_addr_t     entry_addr [`MISS_ENTRIES];
    miss_pkg::line_data_t     entry_data [`MISS_ENTRIES];
    miss_pkg::line_mask_t     entry_mask [`MISS_ENTRIES];
    logic                     entry_dirty [`MISS_ENTRIES];

    miss_pkg::miss_idx_t      head;
    miss_pkg::miss_idx_t      tail;
    logic [COUNT_BITS-1:0]    free_count;

    miss_pkg::line_addr_t     load_line;
    miss_pkg::line_addr_t     store_line;
    logic                     ld_hit;
    miss_pkg::miss_idx_t      ld_hit_idx;
    logic                     ld_ok;
    logic                     ld_alloc;
    logic                     st_hit;
    miss_pkg::miss_idx_t      st_hit_idx;
    logic                     st_join_load;
    logic                     st_blocked;
    logic                     st_room;
    logic                     st_ok;
    logic                     st_alloc;
    miss_pkg::miss_idx_t      st_idx;
    miss_pkg::line_data_t     st_data;
    miss_pkg::line_mask_t     st_mask;

    assign load_line  = load_addr[`ADDR_BITS-1:`LINE_OFFSET_BITS];
    assign store_line = store_addr[`ADDR_BITS-1:`LINE_OFFSET_BITS];

    // a retiring head takes no new loads since its wake walk is over
    always_comb begin
        ld_hit     = 1'b0;
        ld_hit_idx = '0;
        st_hit     = 1'b0;
        st_hit_idx = '0;
        for (int i = 0; i < `MISS_ENTRIES; i++) begin
            if (entry_valid[i] && entry_addr[i] == load_line &&
                !(line_retire && miss_pkg::miss_idx_t'(i) == head)) begin
                ld_hit     = 1'b1;
                ld_hit_idx = miss_pkg::miss_idx_t'(i);
            end
            if (entry_valid[i] && entry_addr[i] == store_line) begin
                st_hit     = 1'b1;
                st_hit_idx = miss_pkg::miss_idx_t'(i);
            end
        end
    end

    assign ld_ok       = load_req && record_free && (ld_hit || free_count != '0);
    assign ld_alloc    = ld_ok && !ld_hit;
    assign load_accept = ld_ok;
    assign load_idx    = ld_hit ? ld_hit_idx : tail;

    // store to the line the load is opening this cycle
    assign st_join_load = ld_alloc && !st_hit && store_line == load_line;
    assign st_blocked   = st_hit && fetch_busy && st_hit_idx == head;
    assign st_room      = free_count > COUNT_BITS'(ld_alloc);
    assign st_ok        = store_req && !st_blocked && (st_hit || st_join_load || st_room);
    assign st_alloc     = st_ok && !st_hit && !st_join_load;
    assign st_idx       = st_hit ? st_hit_idx :
                          st_join_load ? tail : tail + miss_pkg::miss_idx_t'(ld_alloc);

    // byte merge of the store over what the entry already holds
    always_comb begin
        st_data = entry_data[st_idx];
        st_mask = st_hit ? (entry_mask[st_idx] | store_mask) : store_mask;
        for (int w = 0; w < `LINE_WORDS; w++) begin
            for (int b = 0; b < `WORD_BYTES; b++) begin
                if (store_mask[w*`WORD_BYTES + b]) begin
                    st_data[w][b*8 +: 8] = store_data[w][b*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            entry_valid <= '0;
            head        <= '0;
            tail        <= '0;
            free_count  <= COUNT_BITS'(`MISS_ENTRIES);
            load_full   <= 1'b0;
            store_full  <= 1'b0;
        end else begin
            load_full  <= load_req && !ld_ok;
            store_full <= store_req && !st_ok;
            head       <= head + miss_pkg::miss_idx_t'(line_retire);
            tail       <= tail + miss_pkg::miss_idx_t'(ld_alloc) +
                          miss_pkg::miss_idx_t'(st_alloc);
            free_count <= free_count + COUNT_BITS'(line_retire) -
                          COUNT_BITS'(ld_alloc) - COUNT_BITS'(st_alloc);
            if (line_retire) begin
                entry_valid[head] <= 1'b0;
            end
            if (ld_alloc) begin
                entry_valid[tail] <= 1'b1;
            end
            if (st_alloc) begin
                entry_valid[st_idx] <= 1'b1;
            end
        end
    end

    // store write comes last so a joined store lands on the fresh entry
    always_ff @(posedge clk) begin
        if (ld_alloc) begin
            entry_addr[tail]  <= load_line;
            entry_mask[tail]  <= '0;
            entry_dirty[tail] <= 1'b0;
        end
        if (st_ok) begin
            entry_data[st_idx]  <= st_data;
            entry_mask[st_idx]  <= st_mask;
            entry_dirty[st_idx] <= 1'b1;
            if (st_alloc) begin
                entry_addr[st_idx] <= store_line;
            end
        end
    end

    assign head_valid = entry_valid[head];
    assign head_idx   = head;
    assign head_addr  = entry_addr[head];
    assign head_data  = entry_data[head];
    assign head_mask  = entry_mask[head];
    assign head_dirty = entry_dirty[head];

endmodule

// ==== hdl/load_table.sv ====
`timescale 1ns/1ns
`include "miss_params.svh"

module load_table (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  load_accept,
    input  miss_pkg::miss_idx_t   load_idx,
    input  logic [`ADDR_BITS-1:0] load_addr,
    input  miss_pkg::lq_tag_t     load_tag,
    input  miss_pkg::miss_idx_t   wake_idx,
    input  logic                  wake_take,
    output logic                  record_free,
    output logic                  pending_hit,
    output miss_pkg::lq_tag_t     pending_tag,
    output miss_pkg::word_sel_t   pending_sel
);
    localparam int SLOT_BITS = $clog2(`LOAD_RECORDS);

    logic [`LOAD_RECORDS-1:0] rec_valid;
    miss_pkg::miss_idx_t      rec_idx [`LOAD_RECORDS];
    miss_pkg::word_sel_t      rec_sel [`LOAD_RECORDS];
    miss_pkg::lq_tag_t        rec_tag [`LOAD_RECORDS];

    logic [SLOT_BITS-1:0]     free_slot;
    logic [SLOT_BITS-1:0]     take_slot;

    // lowest free slot and lowest waiter on the woken line
    always_comb begin
        free_slot   = '0;
        take_slot   = '0;
        pending_hit = 1'b0;
        for (int i = `LOAD_RECORDS - 1; i >= 0; i--) begin
            if (!rec_valid[i]) begin
                free_slot = SLOT_BITS'(i);
            end
            if (rec_valid[i] && rec_idx[i] == wake_idx) begin
                take_slot   = SLOT_BITS'(i);
                pending_hit = 1'b1;
            end
        end
    end

    assign record_free = !(&rec_valid);
    assign pending_tag = rec_tag[take_slot];
    assign pending_sel = rec_sel[take_slot];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rec_valid <= '0;
        end else begin
            if (load_accept) begin
                rec_valid[free_slot] <= 1'b1;
            end
            if (wake_take) begin
                rec_valid[take_slot] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_accept) begin
            rec_idx[free_slot] <= load_idx;
            rec_sel[free_slot] <= load_addr[`BYTE_OFFSET_BITS +: `WORD_OFFSET_BITS];
            rec_tag[free_slot] <= load_tag;
        end
    end

endmodule

// ==== hdl/fill_engine.sv ====
`timescale 1ns/1ns
`include "miss_params.svh"

module fill_engine (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  head_valid,
    input  miss_pkg::miss_idx_t   head_idx,
    input  miss_pkg::line_addr_t  head_addr,
    input  miss_pkg::line_data_t  head_data,
    input  miss_pkg::line_mask_t  head_mask,
    input  logic                  head_dirty,
    input  logic                  pending_hit,
    input  miss_pkg::lq_tag_t     pending_tag,
    input  miss_pkg::word_sel_t   pending_sel,
    input  logic                  bus_ar_ready,
    input  logic                  bus_r_valid,
    input  miss_pkg::word_t       bus_r_data,
    input  logic                  bus_r_last,
    output logic                  fetch_busy,
    output logic                  line_retire,
    output miss_pkg::miss_idx_t   wake_idx,
    output logic                  wake_take,
    output logic                  bus_ar_valid,
    output logic [`ADDR_BITS-1:0] bus_ar_addr,
    output logic                  refill_valid,
    output logic [`ADDR_BITS-1:0] refill_addr,
    output miss_pkg::line_data_t  refill_data,
    output logic                  refill_dirty,
    output logic                  resp_valid,
    output miss_pkg::lq_tag_t     resp_tag,
    output miss_pkg::word_t       resp_data
);
    miss_pkg::fill_state_t state;
    miss_pkg::word_sel_t   beat;
    miss_pkg::line_addr_t  fetch_line;
    miss_pkg::miss_idx_t   fetch_idx;
    miss_pkg::line_data_t  line_buf;
    miss_pkg::line_data_t  bus_line;
    miss_pkg::line_data_t  merged_line;
    logic                  line_dirty;
    logic                  beat_take;

    assign beat_take = bus_r_valid && state == miss_pkg::fill_collect;

    // bus words so far plus the current beat with stores on top
    always_comb begin
        bus_line       = line_buf;
        bus_line[beat] = bus_r_data;
        for (int w = 0; w < `LINE_WORDS; w++) begin
            for (int b = 0; b < `WORD_BYTES; b++) begin
                merged_line[w][b*8 +: 8] = head_mask[w*`WORD_BYTES + b] ?
                                           head_data[w][b*8 +: 8] : bus_line[w][b*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= miss_pkg::fill_idle;
            beat  <= '0;
        end else begin
            case (state)
                miss_pkg::fill_idle: begin
                    if (head_valid) begin
                        state <= miss_pkg::fill_request;
                    end
                end
                miss_pkg::fill_request: begin
                    if (bus_ar_ready) begin
                        state <= miss_pkg::fill_collect;
                        beat  <= '0;
                    end
                end
                miss_pkg::fill_collect: begin
                    if (bus_r_valid) begin
                        beat <= beat + 1'b1;
                        if (bus_r_last) begin
                            state <= miss_pkg::fill_refill;
                        end
                    end
                end
                miss_pkg::fill_refill: begin
                    state <= miss_pkg::fill_wake;
                end
                miss_pkg::fill_wake: begin
                    // no waiter left on this line
                    if (!pending_hit) begin
                        state <= miss_pkg::fill_idle;
                    end
                end
                default: begin
                    state <= miss_pkg::fill_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == miss_pkg::fill_idle && head_valid) begin
            fetch_line <= head_addr;
            fetch_idx  <= head_idx;
        end
        if (beat_take) begin
            if (bus_r_last) begin
                line_buf   <= merged_line;
                line_dirty <= head_dirty;
            end else begin
                line_buf[beat] <= bus_r_data;
            end
        end
    end

    assign fetch_busy   = state != miss_pkg::fill_idle;
    assign bus_ar_valid = state == miss_pkg::fill_request;
    assign bus_ar_addr  = {fetch_line, {`LINE_OFFSET_BITS{1'b0}}};

    assign refill_valid = state == miss_pkg::fill_refill;
    assign refill_addr  = {fetch_line, {`LINE_OFFSET_BITS{1'b0}}};
    assign refill_data  = line_buf;
    assign refill_dirty = line_dirty;

    // one waiter per cycle
    assign wake_idx    = fetch_idx;
    assign resp_valid  = state == miss_pkg::fill_wake && pending_hit;
    assign wake_take   = resp_valid;
    assign resp_tag    = pending_tag;
    assign resp_data   = line_buf[pending_sel];
    assign line_retire = state == miss_pkg::fill_wake && !pending_hit;

endmodule

// ==== hdl/dcache_miss_unit.sv ====
`timescale 1ns/1ns
`include "miss_params.svh"

module dcache_miss_unit (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  load_req,
    input  logic [`ADDR_BITS-1:0] load_addr,
    input  miss_pkg::lq_tag_t     load_tag,
    output logic                  load_full,
    input  logic                  store_req,
    input  logic [`ADDR_BITS-1:0] store_addr,
    input  miss_pkg::line_data_t  store_data,
    input  miss_pkg::line_mask_t  store_mask,
    output logic                  store_full,
    output logic                  bus_ar_valid,
    output logic [`ADDR_BITS-1:0] bus_ar_addr,
    input  logic                  bus_ar_ready,
    input  logic                  bus_r_valid,
    input  miss_pkg::word_t       bus_r_data,
    input  logic                  bus_r_last,
    output logic                  refill_valid,
    output logic [`ADDR_BITS-1:0] refill_addr,
    output miss_pkg::line_data_t  refill_data,
    output logic                  refill_dirty,
    output logic                  resp_valid,
    output miss_pkg::lq_tag_t     resp_tag,
    output miss_pkg::word_t       resp_data
);
    logic                 record_free;
    logic                 load_accept;
    miss_pkg::miss_idx_t  load_idx;
    logic                 head_valid;
    miss_pkg::miss_idx_t  head_idx;
    miss_pkg::line_addr_t head_addr;
    miss_pkg::line_data_t head_data;
    miss_pkg::line_mask_t head_mask;
    logic                 head_dirty;
    logic                 fetch_busy;
    logic                 line_retire;
    miss_pkg::miss_idx_t  wake_idx;
    logic                 wake_take;
    logic                 pending_hit;
    miss_pkg::lq_tag_t    pending_tag;
    miss_pkg::word_sel_t  pending_sel;

    line_queue i_line_queue (
        .clk         (clk),
        .rst         (rst),
        .load_req    (load_req),
        .load_addr   (load_addr),
        .store_req   (store_req),
        .store_addr  (store_addr),
        .store_data  (store_data),
        .store_mask  (store_mask),
        .record_free (record_free),
        .fetch_busy  (fetch_busy),
        .line_retire (line_retire),
        .load_accept (load_accept),
        .load_idx    (load_idx),
        .load_full   (load_full),
        .store_full  (store_full),
        .head_valid  (head_valid),
        .head_idx    (head_idx),
        .head_addr   (head_addr),
        .head_data   (head_data),
        .head_mask   (head_mask),
        .head_dirty  (head_dirty)
    );

    load_table i_load_table (
        .clk         (clk),
        .rst         (rst),
        .load_accept (load_accept),
        .load_idx    (load_idx),
        .load_addr   (load_addr),
        .load_tag    (load_tag),
        .wake_idx    (wake_idx),
        .wake_take   (wake_take),
        .record_free (record_free),
        .pending_hit (pending_hit),
        .pending_tag (pending_tag),
        .pending_sel (pending_sel)
    );

    fill_engine i_fill_engine (
        .clk          (clk),
        .rst          (rst),
        .head_valid   (head_valid),
        .head_idx     (head_idx),
        .head_addr    (head_addr),
        .head_data    (head_data),
        .head_mask    (head_mask),
        .head_dirty   (head_dirty),
        .pending_hit  (pending_hit),
        .pending_tag  (pending_tag),
        .pending_sel  (pending_sel),
        .bus_ar_ready (bus_ar_ready),
        .bus_r_valid  (bus_r_valid),
        .bus_r_data   (bus_r_data),
        .bus_r_last   (bus_r_last),
        .fetch_busy   (fetch_busy),
        .line_retire  (line_retire),
        .wake_idx     (wake_idx),
        .wake_take    (wake_take),
        .bus_ar_valid (bus_ar_valid),
        .bus_ar_addr  (bus_ar_addr),
        .refill_valid (refill_valid),
        .refill_addr  (refill_addr),
        .refill_data  (refill_data),
        .refill_dirty (refill_dirty),
        .resp_valid   (resp_valid),
        .resp_tag     (resp_tag),
        .resp_data    (resp_data)
    );

endmodule

// ==== bench/mem_responder.sv ====
`timescale 1ns/1ns
`include "miss_params.svh"

module mem_responder (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  hold,
    input  logic                  ar_valid,
    input  logic [`ADDR_BITS-1:0] ar_addr,
    output logic                  ar_ready,
    output logic                  r_valid,
    output logic [`WORD_BITS-1:0] r_data,
    output logic                  r_last
);
    logic                  busy = 1'b0;
    int                    delay = 0;
    int                    beat = 0;
    logic [`ADDR_BITS-1:0] word_addr = '0;
    logic                  next_ready;
    logic                  next_valid;
    logic [`WORD_BITS-1:0] next_data;
    logic                  next_last;

    initial begin
        ar_ready = 1'b0;
        r_valid  = 1'b0;
        r_data   = '0;
        r_last   = 1'b0;
    end

    always @(posedge clk) begin
        next_ready = 1'b0;
        next_valid = 1'b0;
        next_data  = '0;
        next_last  = 1'b0;
        if (!rst) begin
            busy = 1'b0;
        end else begin
            if (busy && beat == `LINE_WORDS) begin
                busy = 1'b0;
            end
            // first beat two cycles after the accept edge
            if (busy) begin
                if (delay != 0) begin
                    delay = delay - 1;
                end
                if (delay == 0) begin
                    next_valid = 1'b1;
                    next_data  = (word_addr + `ADDR_BITS'(beat)) ^ 32'h5a5a_0000;
                    next_last  = beat == `LINE_WORDS - 1;
                    beat       = beat + 1;
                end
            end
            if (!busy && ar_valid && ar_ready) begin
                busy      = 1'b1;
                delay     = 2;
                beat      = 0;
                word_addr = ar_addr >> 2;
            end
            next_ready = !busy && !hold && ($urandom % 3 != 0);
        end
        #5;
        ar_ready = next_ready;
        r_valid  = next_valid;
        r_data   = next_data;
        r_last   = next_last;
    end

endmodule

// ==== bench/tb_dcache_miss.sv ====
`timescale 1ns/1ns
`include "miss_params.svh"

module tb_dcache_miss;
    localparam int CYCLE_LIMIT = 3000;
    localparam int LINE_BYTES  = `LINE_WORDS * `WORD_BITS / 8;

    logic                  clk;
    logic                  rst;
    logic                  load_req;
    logic [`ADDR_BITS-1:0] load_addr;
    miss_pkg::lq_tag_t     load_tag;
    logic                  load_full;
    logic                  store_req;
    logic [`ADDR_BITS-1:0] store_addr;
    miss_pkg::line_data_t  store_data;
    miss_pkg::line_mask_t  store_mask;
    logic                  store_full;
    logic                  bus_ar_valid;
    logic [`ADDR_BITS-1:0] bus_ar_addr;
    logic                  bus_ar_ready;
    logic                  bus_r_valid;
    miss_pkg::word_t       bus_r_data;
    logic                  bus_r_last;
    logic                  refill_valid;
    logic [`ADDR_BITS-1:0] refill_addr;
    miss_pkg::line_data_t  refill_data;
    logic                  refill_dirty;
    logic                  resp_valid;
    miss_pkg::lq_tag_t     resp_tag;
    miss_pkg::word_t       resp_data;
    logic                  bus_hold;

    string                 test_name;
    int                    errors = 0;
    int                    cycles = 0;
    logic                  load_reject;
    logic                  store_reject;
    logic                  load_reject_d = 1'b0;
    logic                  store_reject_d = 1'b0;
    logic                  ar_wait = 1'b0;
    logic [`ADDR_BITS-1:0] ar_addr_d = '0;
    logic                  fetch_open = 1'b0;
    logic                  last_beat_d = 1'b0;
    logic [`ADDR_BITS-1:0] refill_q [$];
    logic [`ADDR_BITS-1:0] resp_addr [int];
    miss_pkg::line_data_t  model_data [logic [`ADDR_BITS-1:0]];
    miss_pkg::line_mask_t  model_mask [logic [`ADDR_BITS-1:0]];
    miss_pkg::line_data_t  exp_line;
    logic                  exp_dirty;

    dcache_miss_unit i_dcache_miss_unit (.*);

    mem_responder i_mem_responder (
        .clk      (clk),
        .rst      (rst),
        .hold     (bus_hold),
        .ar_valid (bus_ar_valid),
        .ar_addr  (bus_ar_addr),
        .ar_ready (bus_ar_ready),
        .r_valid  (bus_r_valid),
        .r_data   (bus_r_data),
        .r_last   (bus_r_last)
    );

    always #20 clk = ~clk;

    function automatic logic [`ADDR_BITS-1:0] line_base(input logic [`ADDR_BITS-1:0] addr);
        return addr & ~`ADDR_BITS'(LINE_BYTES - 1);
    endfunction

    function automatic logic line_pending(input logic [`ADDR_BITS-1:0] base);
        foreach (refill_q[i]) begin
            if (refill_q[i] == base) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // memory word with any stored bytes of its line on top
    function automatic miss_pkg::word_t expected_word(input logic [`ADDR_BITS-1:0] addr);
        logic [`ADDR_BITS-1:0] base;
        miss_pkg::line_data_t  line;
        miss_pkg::line_mask_t  mask;
        miss_pkg::word_t       word;
        int                    w;
        base = line_base(addr);
        w    = int'((addr % LINE_BYTES) / 4);
        word = (addr >> 2) ^ 32'h5a5a_0000;
        if (model_mask.exists(base)) begin
            line = model_data[base];
            mask = model_mask[base];
            for (int b = 0; b < 4; b++) begin
                if (mask[w*4 + b]) begin
                    word[b*8 +: 8] = line[w][b*8 +: 8];
                end
            end
        end
        return word;
    endfunction

    function automatic miss_pkg::line_data_t expected_line(input logic [`ADDR_BITS-1:0] base);
        miss_pkg::line_data_t line;
        for (int w = 0; w < `LINE_WORDS; w++) begin
            line[w] = expected_word(base + `ADDR_BITS'(4 * w));
        end
        return line;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #5;
    endtask

    task automatic send_load(input logic [`ADDR_BITS-1:0] addr, input int tag,
                             input logic reject);
        load_req    = 1'b1;
        load_addr   = addr;
        load_tag    = miss_pkg::lq_tag_t'(tag);
        load_reject = reject;
        if (!reject) begin
            resp_addr[tag] = addr;
            if (!line_pending(line_base(addr))) begin
                refill_q.push_back(line_base(addr));
            end
        end
        next_cycle();
        load_req    = 1'b0;
        load_reject = 1'b0;
    endtask

    task automatic send_store(input logic [`ADDR_BITS-1:0] addr, input miss_pkg::line_data_t data,
                              input miss_pkg::line_mask_t mask, input logic reject);
        logic [`ADDR_BITS-1:0] base;
        miss_pkg::line_data_t  line;
        base         = line_base(addr);
        store_req    = 1'b1;
        store_addr   = addr;
        store_data   = data;
        store_mask   = mask;
        store_reject = reject;
        if (!reject) begin
            if (!line_pending(base)) begin
                refill_q.push_back(base);
            end
            if (!model_mask.exists(base)) begin
                model_data[base] = '0;
                model_mask[base] = '0;
            end
            line = model_data[base];
            for (int i = 0; i < LINE_BYTES; i++) begin
                if (mask[i]) begin
                    line[i/4][(i%4)*8 +: 8] = data[i/4][(i%4)*8 +: 8];
                end
            end
            model_data[base] = line;
            model_mask[base] = model_mask[base] | mask;
        end
        next_cycle();
        store_req    = 1'b0;
        store_reject = 1'b0;
    endtask

    // every refill and wake-up seen and then the retire cycle
    task automatic wait_drained();
        while (refill_q.size() != 0 || resp_addr.num() != 0) begin
            next_cycle();
        end
        next_cycle();
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            assert (!bus_ar_valid && !refill_valid && !resp_valid && !load_full && !store_full)
            else begin
                $display("%s: an output is high while reset is held", test_name);
                errors++;
            end
        end else begin
            assert (load_full == load_reject_d) else begin
                $display("Mismatch in %s: load_full expected %0b actual %0b",
                         test_name, load_reject_d, load_full);
                errors++;
            end
            assert (store_full == store_reject_d) else begin
                $display("Mismatch in %s: store_full expected %0b actual %0b",
                         test_name, store_reject_d, store_full);
                errors++;
            end
            if (ar_wait) begin
                assert (bus_ar_valid && bus_ar_addr == ar_addr_d) else begin
                    $display("%s: bus request dropped or moved before ready", test_name);
                    errors++;
                end
            end
            if (bus_ar_valid && bus_ar_ready) begin
                assert (!fetch_open && refill_q.size() != 0) else begin
                    $display("%s: bus request with no line waiting for it", test_name);
                    errors++;
                end
                if (refill_q.size() != 0) begin
                    assert (bus_ar_addr == refill_q[0]) else begin
                        $display("Mismatch in %s: bus address expected %h actual %h",
                                 test_name, refill_q[0], bus_ar_addr);
                        errors++;
                    end
                end
                fetch_open = 1'b1;
            end
            assert (refill_valid == last_beat_d) else begin
                $display("%s: refill strobe not one cycle after the last beat", test_name);
                errors++;
            end
            if (refill_valid) begin
                assert (refill_q.size() != 0) else begin
                    $display("%s: refill with no line expected", test_name);
                    errors++;
                end
            end
            if (refill_valid && refill_q.size() != 0) begin
                exp_line  = expected_line(refill_q[0]);
                exp_dirty = model_mask.exists(refill_q[0]) != 0;
                assert (refill_addr == refill_q[0]) else begin
                    $display("Mismatch in %s: refill address expected %h actual %h",
                             test_name, refill_q[0], refill_addr);
                    errors++;
                end
                assert (refill_data == exp_line) else begin
                    $display("Mismatch in %s: refill data expected %h actual %h",
                             test_name, exp_line, refill_data);
                    errors++;
                end
                assert (refill_dirty == exp_dirty) else begin
                    $display("Mismatch in %s: refill dirty expected %0b actual %0b",
                             test_name, exp_dirty, refill_dirty);
                    errors++;
                end
                void'(refill_q.pop_front());
                fetch_open = 1'b0;
            end
            if (resp_valid) begin
                assert (resp_addr.exists(int'(resp_tag))) else begin
                    $display("%s: response for tag %0d with no load waiting",
                             test_name, resp_tag);
                    errors++;
                end
            end
            if (resp_valid && resp_addr.exists(int'(resp_tag))) begin
                assert (resp_data == expected_word(resp_addr[int'(resp_tag)])) else begin
                    $display("Mismatch in %s: tag %0d data expected %h actual %h", test_name,
                             resp_tag, expected_word(resp_addr[int'(resp_tag)]), resp_data);
                    errors++;
                end
                resp_addr.delete(int'(resp_tag));
            end
        end
        load_reject_d  = load_req && load_reject;
        store_reject_d = store_req && store_reject;
        ar_wait        = rst && bus_ar_valid && !bus_ar_ready;
        ar_addr_d      = bus_ar_addr;
        last_beat_d    = rst && bus_r_valid && bus_r_last;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("run stopped at the cycle limit in %s, %0d errors", test_name, errors);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h6c4a_3c0f));
        clk          = 1'b0;
        rst          = 1'b0;
        load_req     = 1'b0;
        load_addr    = '0;
        load_tag     = '0;
        store_req    = 1'b0;
        store_addr   = '0;
        store_data   = '0;
        store_mask   = '0;
        bus_hold     = 1'b0;
        load_reject  = 1'b0;
        store_reject = 1'b0;
        test_name    = "reset";
        repeat (8) @(posedge clk);
        #5;
        rst = 1'b1;
        next_cycle();

        test_name = "single_load";
        send_load(32'h0000_1004, 1, 1'b0);
        wait_drained();

        test_name = "same_line_loads";
        send_load(32'h0000_2024, 2, 1'b0);
        send_load(32'h0000_202c, 3, 1'b0);
        wait_drained();

        // bytes 2 and 3 of word 2 come from the store
        test_name = "store_merge";
        send_store(32'h0000_3040, {32'h8899_aabb, 32'h4455_6677, 32'h0011_2233, 32'hccdd_eeff},
                   16'h0c36, 1'b0);
        send_load(32'h0000_3048, 4, 1'b0);
        wait_drained();

        test_name = "queue_full";
        bus_hold  = 1'b1;
        send_load(32'h0000_4000, 10, 1'b0);
        send_load(32'h0000_4044, 11, 1'b0);
        send_load(32'h0000_4088, 12, 1'b0);
        send_load(32'h0000_40cc, 13, 1'b0);
        send_load(32'h0000_4100, 14, 1'b1);
        bus_hold = 1'b0;
        wait_drained();

        test_name = "fetch_collision";
        send_load(32'h0000_5064, 20, 1'b0);
        while (!bus_ar_valid) begin
            next_cycle();
        end
        send_store(32'h0000_5060, {4{32'h1111_1111}}, 16'hffff, 1'b1);
        wait_drained();

        $display("run finished, %0d errors", errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+hdl
hdl/miss_pkg.sv
hdl/line_queue.sv
hdl/load_table.sv
hdl/fill_engine.sv
hdl/dcache_miss_unit.sv
bench/mem_responder.sv
bench/tb_dcache_miss.sv

// ==== run.sh ====
#!/bin/sh
# build and run the miss unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module tb_dcache_miss -Mdir obj_dir -o sim_dcache_miss
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/sim_dcache_miss)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^TEST PASSED$"; then
    exit 0
fi
exit 1
